//--- cache_pkg.sv
package cache_pkg;

   localparam int ADDR_W        = 16;
   localparam int FE_DATA_W     = 32;
   localparam int FE_NBYTES     = 4;
   localparam int BE_DATA_W     = 64;
   localparam int BE_NBYTES     = 8;
   localparam int BYTE_OFF_W    = 2;  // byte bits of a front-end word
   localparam int WORD_OFFSET_W = 2;  // 4 words per line
   localparam int INDEX_W       = 4;  // 16 lines
   localparam int TAG_W         = ADDR_W - BYTE_OFF_W - WORD_OFFSET_W - INDEX_W;
   localparam int NLINES        = 2**INDEX_W;
   localparam int NWORDS        = 2**(INDEX_W + WORD_OFFSET_W);
   localparam int WBUF_DEPTH    = 4;

   typedef struct packed {
      logic [ADDR_W-1:0]    addr;
      logic                 we;
      logic [FE_NBYTES-1:0] wstrb;
      logic [FE_DATA_W-1:0] wdata;
   } fe_req_t;

   typedef struct packed {
      logic [ADDR_W-BYTE_OFF_W-1:0] waddr;  // word address
      logic [FE_NBYTES-1:0]         wstrb;
      logic [FE_DATA_W-1:0]         wdata;
   } wbuf_entry_t;

   typedef struct packed {
      logic [ADDR_W-1:0]    addr;  // 8-byte aligned
      logic [BE_NBYTES-1:0] wstrb;
      logic [BE_DATA_W-1:0] wdata;
   } mem_wr_t;

   function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] addr);
      return addr[BYTE_OFF_W+WORD_OFFSET_W +: INDEX_W];
   endfunction

   function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
      return addr[ADDR_W-1 -: TAG_W];
   endfunction

   // word position inside the data array, line index on top
   function automatic logic [INDEX_W+WORD_OFFSET_W-1:0] addr_word(input logic [ADDR_W-1:0] addr);
      return addr[BYTE_OFF_W +: INDEX_W+WORD_OFFSET_W];
   endfunction

endpackage

//--- cache_tag_store.sv
`timescale 1ns/1ns

module cache_tag_store (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [cache_pkg::ADDR_W-1:0] lookup_addr,
   output logic                      hit,
   input  logic                      fill_en,
   input  logic [cache_pkg::ADDR_W-1:0] fill_addr
);

   import cache_pkg::*;

   logic [NLINES-1:0] valid;
   logic [TAG_W-1:0]  tags [NLINES];

   assign hit = valid[addr_index(lookup_addr)] &
                (tags[addr_index(lookup_addr)] == addr_tag(lookup_addr));

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         valid <= '0;
      end else if (fill_en) begin
         valid[addr_index(fill_addr)] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         tags[addr_index(fill_addr)] <= addr_tag(fill_addr);  // line now owned by this tag
      end
   end

endmodule

//--- cache_data_store.sv
`timescale 1ns/1ns

module cache_data_store (
   input  logic                         clk,
   input  logic [cache_pkg::ADDR_W-1:0]    rd_addr,
   output logic [cache_pkg::FE_DATA_W-1:0] rdata,
   input  logic                         wr_en,
   input  logic [cache_pkg::ADDR_W-1:0]    wr_addr,
   input  logic [cache_pkg::FE_NBYTES-1:0] wr_strb,
   input  logic [cache_pkg::FE_DATA_W-1:0] wr_data,
   input  logic                         fill_en,
   input  logic [cache_pkg::ADDR_W-1:0]    fill_addr,
   input  logic                         fill_half,
   input  logic [cache_pkg::BE_DATA_W-1:0] fill_data
);

   import cache_pkg::*;

   logic [FE_DATA_W-1:0]             mem [NWORDS];
   logic [INDEX_W+WORD_OFFSET_W-1:0] wr_word;
   logic [INDEX_W+WORD_OFFSET_W-1:0] fill_lo;
   logic [INDEX_W+WORD_OFFSET_W-1:0] fill_hi;

   assign wr_word = addr_word(wr_addr);
   assign fill_lo = {addr_index(fill_addr), fill_half, 1'b0};  // lower word of the beat
   assign fill_hi = {addr_index(fill_addr), fill_half, 1'b1};

   assign rdata = mem[addr_word(rd_addr)];

   always_ff @(posedge clk) begin
      if (fill_en) begin
         mem[fill_lo] <= fill_data[FE_DATA_W-1:0];
         mem[fill_hi] <= fill_data[BE_DATA_W-1:FE_DATA_W];
      end else if (wr_en) begin
         for (int b = 0; b < FE_NBYTES; b++) begin
            if (wr_strb[b]) begin
               mem[wr_word][8*b +: 8] <= wr_data[8*b +: 8];  // merge enabled bytes only
            end
         end
      end
   end

endmodule

//--- cache_write_buffer.sv
`timescale 1ns/1ns

module cache_write_buffer #(
   parameter int DEPTH = cache_pkg::WBUF_DEPTH
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   push,
   input  cache_pkg::wbuf_entry_t din,
   input  logic                   pop,
   output cache_pkg::wbuf_entry_t head,
   output logic                   not_empty,
   output logic                   empty,
   output logic                   full
);

   import cache_pkg::*;

   wbuf_entry_t                mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       do_push;
   logic                       do_pop;

   assign do_pop  = pop & ~empty;
   assign do_push = push & (~full | do_pop);  // full is fine if a slot frees up

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head      = mem[rd_ptr];
   assign empty     = (count == 0);
   assign not_empty = ~empty;
   assign full      = (count == DEPTH);

endmodule

//--- cache_write_channel.sv
`timescale 1ns/1ns

module cache_write_channel (
   input  logic                   clk,
   input  logic                   reset,
   input  cache_pkg::wbuf_entry_t head,
   input  logic                   not_empty,
   output logic                   pop,
   output logic                   mem_w_valid,
   output cache_pkg::mem_wr_t     mem_w,
   input  logic                   mem_w_ready
);

   import cache_pkg::*;

   typedef enum logic {
      W_IDLE,
      W_WRITE
   } state_t;

   state_t state;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state <= W_IDLE;
      end else begin
         case (state)
            W_IDLE:  if (not_empty) state <= W_WRITE;
            default: if (mem_w_ready) state <= W_IDLE;  // beat taken
         endcase
      end
   end

   assign mem_w_valid = (state == W_WRITE);
   assign pop         = mem_w_valid & mem_w_ready;

   always_comb begin
      mem_w.addr  = {head.waddr[ADDR_W-BYTE_OFF_W-1:1], {(BYTE_OFF_W+1){1'b0}}};
      mem_w.wdata = {2{head.wdata}};  // same word on both halves
      if (head.waddr[0]) begin
         mem_w.wstrb = {head.wstrb, {FE_NBYTES{1'b0}}};  // upper lanes
      end else begin
         mem_w.wstrb = {{FE_NBYTES{1'b0}}, head.wstrb};
      end
   end

endmodule

//--- cache_read_channel.sv
`timescale 1ns/1ns

module cache_read_channel (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         refill_start,
   input  logic [cache_pkg::ADDR_W-1:0]    miss_addr,
   output logic                         mem_r_valid,
   output logic [cache_pkg::ADDR_W-1:0]    mem_r_addr,
   input  logic                         mem_r_ready,
   input  logic [cache_pkg::BE_DATA_W-1:0] mem_r_rdata,
   output logic                         data_fill_en,
   output logic                         fill_half,
   output logic [cache_pkg::BE_DATA_W-1:0] fill_data,
   output logic                         tag_fill_en,
   output logic                         refill_done
);

   import cache_pkg::*;

   typedef enum logic [1:0] {
      R_IDLE,
      R_READ,
      R_DONE
   } state_t;

   state_t                                     state;
   logic                                       beat;
   logic [ADDR_W-BYTE_OFF_W-WORD_OFFSET_W-1:0] line_q;

   always_ff @(posedge clk) begin
      if (refill_start && state == R_IDLE) begin
         line_q <= miss_addr[ADDR_W-1:BYTE_OFF_W+WORD_OFFSET_W];
      end
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state <= R_IDLE;
         beat  <= 1'b0;
      end else begin
         case (state)
            R_IDLE: begin
               beat <= 1'b0;
               if (refill_start) state <= R_READ;
            end
            R_READ: begin
               if (mem_r_ready) begin
                  beat <= 1'b1;
                  if (beat) state <= R_DONE;  // second half in
               end
            end
            default: state <= R_IDLE;
         endcase
      end
   end

   assign mem_r_valid  = (state == R_READ);
   assign mem_r_addr   = {line_q, beat, {(BYTE_OFF_W+WORD_OFFSET_W-1){1'b0}}};
   assign data_fill_en = mem_r_valid & mem_r_ready;
   assign fill_half    = beat;
   assign fill_data    = mem_r_rdata;
   assign tag_fill_en  = (state == R_DONE);  // tag only once both halves landed
   assign refill_done  = (state == R_DONE);

endmodule

//--- cache_control.sv
`timescale 1ns/1ns

module cache_control (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         req_valid,
   output logic                         req_ready,
   input  cache_pkg::fe_req_t           req,
   output logic                         resp_valid,
   output logic [cache_pkg::FE_DATA_W-1:0] resp_rdata,
   input  logic                         hit,
   input  logic [cache_pkg::FE_DATA_W-1:0] rdata,
   output logic [cache_pkg::ADDR_W-1:0]    lookup_addr,
   output logic                         wr_en,
   output logic [cache_pkg::FE_NBYTES-1:0] wr_strb,
   output logic [cache_pkg::FE_DATA_W-1:0] wr_data,
   output logic                         push,
   output cache_pkg::wbuf_entry_t       push_entry,
   input  logic                         full,
   input  logic                         empty,
   output logic                         refill_start,
   input  logic                         refill_done
);

   import cache_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      DRAIN_WAIT,
      REFILL
   } state_t;

   state_t  state;
   fe_req_t req_q;
   logic    in_lookup;

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         req_q <= req;
      end
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: if (req_valid) state <= LOOKUP;
            LOOKUP: begin
               if (req_q.we) begin
                  if (!full) state <= IDLE;  // else hold until a slot frees
               end else if (hit) begin
                  state <= IDLE;
               end else begin
                  state <= DRAIN_WAIT;
               end
            end
            DRAIN_WAIT: if (empty) state <= REFILL;  // older writes reach memory first
            default: if (refill_done) state <= LOOKUP;
         endcase
      end
   end

   assign in_lookup   = (state == LOOKUP);
   assign req_ready   = (state == IDLE);
   assign lookup_addr = req_q.addr;

   assign push    = in_lookup & req_q.we & ~full;
   assign wr_en   = push & hit;  // no allocate on a write miss
   assign wr_strb = req_q.wstrb;
   assign wr_data = req_q.wdata;

   assign push_entry.waddr = req_q.addr[ADDR_W-1:BYTE_OFF_W];
   assign push_entry.wstrb = req_q.wstrb;
   assign push_entry.wdata = req_q.wdata;

   assign resp_valid   = in_lookup & ~req_q.we & hit;
   assign resp_rdata   = rdata;
   assign refill_start = (state == DRAIN_WAIT) & empty;

endmodule

//--- wt_cache_top.sv
`timescale 1ns/1ns

module wt_cache_top (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         req_valid,
   output logic                         req_ready,
   input  cache_pkg::fe_req_t           req,
   output logic                         resp_valid,
   output logic [cache_pkg::FE_DATA_W-1:0] resp_rdata,
   output logic                         mem_w_valid,
   output cache_pkg::mem_wr_t           mem_w,
   input  logic                         mem_w_ready,
   output logic                         mem_r_valid,
   output logic [cache_pkg::ADDR_W-1:0]    mem_r_addr,
   input  logic                         mem_r_ready,
   input  logic [cache_pkg::BE_DATA_W-1:0] mem_r_rdata
);

   import cache_pkg::*;

   logic                 hit;
   logic [FE_DATA_W-1:0] rdata;
   logic [ADDR_W-1:0]    lookup_addr;
   logic                 wr_en;
   logic [FE_NBYTES-1:0] wr_strb;
   logic [FE_DATA_W-1:0] wr_data;
   logic                 push;
   wbuf_entry_t          push_entry;
   wbuf_entry_t          wb_head;
   logic                 wb_pop;
   logic                 wb_not_empty;
   logic                 wb_empty;
   logic                 wb_full;
   logic                 refill_start;
   logic                 refill_done;
   logic                 data_fill_en;
   logic                 fill_half;
   logic [BE_DATA_W-1:0] fill_data;
   logic                 tag_fill_en;

   cache_control u_cache_control (
      .clk, .reset,
      .req_valid, .req_ready, .req,
      .resp_valid, .resp_rdata,
      .hit, .rdata, .lookup_addr,
      .wr_en, .wr_strb, .wr_data,
      .push, .push_entry,
      .full         (wb_full),
      .empty        (wb_empty),
      .refill_start, .refill_done
   );

   cache_tag_store u_cache_tag_store (
      .clk, .reset,
      .lookup_addr, .hit,
      .fill_en      (tag_fill_en),
      .fill_addr    (mem_r_addr)
   );

   cache_data_store u_cache_data_store (
      .clk,
      .rd_addr      (lookup_addr),
      .rdata,
      .wr_en,
      .wr_addr      (lookup_addr),
      .wr_strb, .wr_data,
      .fill_en      (data_fill_en),
      .fill_addr    (mem_r_addr),
      .fill_half, .fill_data
   );

   cache_write_buffer #(
      .DEPTH        (WBUF_DEPTH)
   ) u_cache_write_buffer (
      .clk, .reset,
      .push,
      .din          (push_entry),
      .pop          (wb_pop),
      .head         (wb_head),
      .not_empty    (wb_not_empty),
      .empty        (wb_empty),
      .full         (wb_full)
   );

   cache_write_channel u_cache_write_channel (
      .clk, .reset,
      .head         (wb_head),
      .not_empty    (wb_not_empty),
      .pop          (wb_pop),
      .mem_w_valid, .mem_w, .mem_w_ready
   );

   cache_read_channel u_cache_read_channel (
      .clk, .reset,
      .refill_start,
      .miss_addr    (lookup_addr),
      .mem_r_valid, .mem_r_addr, .mem_r_ready, .mem_r_rdata,
      .data_fill_en, .fill_half, .fill_data,
      .tag_fill_en, .refill_done
   );

endmodule

//--- tb_backend_mem.sv
`timescale 1ns/1ns

module tb_backend_mem (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            mem_w_valid,
   input  cache_pkg::mem_wr_t              mem_w,
   output logic                            mem_w_ready,
   input  logic                            mem_r_valid,
   input  logic [cache_pkg::ADDR_W-1:0]    mem_r_addr,
   output logic                            mem_r_ready,
   output logic [cache_pkg::BE_DATA_W-1:0] mem_r_rdata
);

   import cache_pkg::*;

   localparam int NBEATS = 2**(ADDR_W-3);

   logic [BE_DATA_W-1:0] mem [NBEATS];
   int unsigned          seed;

   initial begin
      for (int i = 0; i < NBEATS; i++) begin
         mem[i] = {32'(i*8 + 4) ^ 32'h5a5a_0000, 32'(i*8) ^ 32'h5a5a_0000};  // own byte address
      end
   end

   initial begin
      mem_w_ready = 1'b0;
      mem_r_ready = 1'b0;
      seed        = 32'h430c_897f;
      void'($urandom(seed));
      forever begin
         @(posedge clk);
         #10;
         mem_w_ready = ($urandom % 3) == 0;  // ready about one cycle in three
         mem_r_ready = ($urandom % 2) == 0;
      end
   end

   always @(posedge clk) begin
      if (!reset && mem_w_valid && mem_w_ready) begin
         for (int b = 0; b < BE_NBYTES; b++) begin
            if (mem_w.wstrb[b]) begin
               mem[mem_w.addr[ADDR_W-1:3]][8*b +: 8] <= mem_w.wdata[8*b +: 8];
            end
         end
      end
   end

   assign mem_r_rdata = mem_r_valid ? mem[mem_r_addr[ADDR_W-1:3]] : 'x;  // only for a pending read

endmodule

//--- tb_wt_cache.sv
`timescale 1ns/1ns

module tb_wt_cache;

   import cache_pkg::*;

   localparam int WAIT_LIMIT = 400;  // cycles
   localparam int NWORDS_MEM = 2**(ADDR_W-2);

   typedef struct packed {
      fe_req_t req;
      logic    exp_hit;  // reads only
   } step_t;

   logic                 clk;
   logic                 reset;
   logic                 req_valid;
   logic                 req_ready;
   fe_req_t              req;
   logic                 resp_valid;
   logic [FE_DATA_W-1:0] resp_rdata;
   logic                 mem_w_valid;
   mem_wr_t              mem_w;
   logic                 mem_w_ready;
   logic                 mem_r_valid;
   logic [ADDR_W-1:0]    mem_r_addr;
   logic                 mem_r_ready;
   logic [BE_DATA_W-1:0] mem_r_rdata;

   step_t                steps [$];
   mem_wr_t              exp_beats [$];
   logic [FE_DATA_W-1:0] shadow [NWORDS_MEM];
   int                   errors;
   int                   beats;
   bit                   timed_out;

   wt_cache_top u_wt_cache_top (
      .clk, .reset,
      .req_valid, .req_ready, .req,
      .resp_valid, .resp_rdata,
      .mem_w_valid, .mem_w, .mem_w_ready,
      .mem_r_valid, .mem_r_addr, .mem_r_ready, .mem_r_rdata
   );

   tb_backend_mem u_tb_backend_mem (
      .clk, .reset,
      .mem_w_valid, .mem_w, .mem_w_ready,
      .mem_r_valid, .mem_r_addr, .mem_r_ready, .mem_r_rdata
   );

   always #50 clk = ~clk;

   function automatic logic [FE_DATA_W-1:0] preload_word(input int waddr);
      return (waddr * 4) ^ 32'h5a5a_0000;
   endfunction

   // beat as the back end must see it for one front-end write
   function automatic mem_wr_t expected_beat(input fe_req_t r);
      mem_wr_t b;
      b.addr  = {r.addr[ADDR_W-1:3], 3'b000};
      b.wdata = {r.wdata, r.wdata};
      b.wstrb = r.addr[2] ? {r.wstrb, 4'b0000} : {4'b0000, r.wstrb};
      return b;
   endfunction

   task automatic add_step(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [FE_NBYTES-1:0] wstrb, input logic [FE_DATA_W-1:0] wdata,
                           input logic exp_hit);
      step_t s;
      s.req.we    = we;
      s.req.addr  = addr;
      s.req.wstrb = wstrb;
      s.req.wdata = wdata;
      s.exp_hit   = exp_hit;
      steps.push_back(s);
   endtask

   task automatic fill_table();
      add_step(0, 16'h0100, 4'h0, 32'h0, 0);  // cold miss
      add_step(0, 16'h0104, 4'h0, 32'h0, 1);
      add_step(0, 16'h010c, 4'h0, 32'h0, 1);
      add_step(1, 16'h0104, 4'b0101, 32'h1122_3344, 0);  // partial write hit
      add_step(0, 16'h0104, 4'h0, 32'h0, 1);
      add_step(1, 16'h0208, 4'b1111, 32'hcafe_f00d, 0);  // write miss, no allocate
      add_step(0, 16'h0208, 4'h0, 32'h0, 0);
      add_step(0, 16'h0104, 4'h0, 32'h0, 0);
      add_step(0, 16'h0530, 4'h0, 32'h0, 0);  // index 3 ping-pong
      add_step(0, 16'h0630, 4'h0, 32'h0, 0);
      add_step(0, 16'h0534, 4'h0, 32'h0, 0);
      add_step(0, 16'h0634, 4'h0, 32'h0, 0);
      add_step(1, 16'h0630, 4'b1000, 32'ha1b2_c3d4, 0);  // burst under stalls
      add_step(1, 16'h0700, 4'b1111, 32'h0123_4567, 0);
      add_step(1, 16'h0704, 4'b0011, 32'h89ab_cdef, 0);
      add_step(1, 16'h0708, 4'b1100, 32'hfedc_ba98, 0);
      add_step(1, 16'h070c, 4'b0001, 32'h1357_9bdf, 0);
      add_step(1, 16'h0634, 4'b0110, 32'h2468_ace0, 0);
      add_step(1, 16'h0700, 4'b1100, 32'hdead_beef, 0);
      add_step(1, 16'h0638, 4'b1111, 32'h55aa_55aa, 0);
      add_step(0, 16'h0630, 4'h0, 32'h0, 1);
      add_step(0, 16'h0700, 4'h0, 32'h0, 0);
      add_step(0, 16'h0704, 4'h0, 32'h0, 1);
      add_step(0, 16'h070c, 4'h0, 32'h0, 1);
      add_step(0, 16'h0638, 4'h0, 32'h0, 1);
      add_step(0, 16'h0634, 4'h0, 32'h0, 1);
   endtask

   task automatic update_shadow(input fe_req_t r);
      int w;
      w = r.addr[ADDR_W-1:2];
      for (int b = 0; b < FE_NBYTES; b++) begin
         if (r.wstrb[b]) begin
            shadow[w][8*b +: 8] = r.wdata[8*b +: 8];
         end
      end
   endtask

   task automatic check_rdata(input logic [FE_DATA_W-1:0] got, input logic [FE_DATA_W-1:0] exp,
                              input logic [ADDR_W-1:0] addr);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: read %h returned %h, expected %h", $time, addr, got, exp);
      end
   endtask

   task automatic check_mem_wr(input mem_wr_t got, input mem_wr_t exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: beat addr %h strb %b data %h, expected addr %h strb %b data %h",
                  $time, got.addr, got.wstrb, got.wdata, exp.addr, exp.wstrb, exp.wdata);
      end
   endtask

   task automatic check_latency(input int cycles, input logic exp_hit,
                                input logic [ADDR_W-1:0] addr);
      if (exp_hit ? (cycles != 1) : (cycles == 1)) begin
         errors++;
         $display("ERR %0t: read %h answered after %0d cycles, expected a %s", $time, addr,
                  cycles, exp_hit ? "hit" : "miss");
      end
   endtask

   task automatic send_request(input fe_req_t r, output bit ok);
      int n;
      @(posedge clk);
      #10;
      req       = r;
      req_valid = 1'b1;
      n         = 0;
      @(negedge clk);
      while (!req_ready && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      ok = req_ready;
      if (!ok) begin
         $display("timeout: req_ready stayed low for %0d cycles", WAIT_LIMIT);
      end else begin
         if (r.we) begin
            exp_beats.push_back(expected_beat(r));
            update_shadow(r);
         end
         @(posedge clk);  // acceptance edge
         #10;
         req_valid = 1'b0;
      end
   endtask

   task automatic wait_response(output int cycles, output logic [FE_DATA_W-1:0] data,
                                output bit ok);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!resp_valid && cycles < WAIT_LIMIT);
      ok   = resp_valid;
      data = resp_rdata;
      if (!ok) begin
         $display("timeout: no read response within %0d cycles", WAIT_LIMIT);
      end
   endtask

   task automatic wait_beats_drained(output bit ok);
      int n;
      n = 0;
      while (exp_beats.size() != 0 && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      ok = (exp_beats.size() == 0);
      if (!ok) begin
         $display("timeout: %0d writes never reached the back end", exp_beats.size());
      end
   endtask

   // beat transfers on the next rising edge
   always @(negedge clk) begin
      if (!reset && mem_r_valid && exp_beats.size() != 0) begin
         errors++;
         $display("read at %0t went to the back end ahead of an older write", $time);
      end
      if (!reset && mem_w_valid && mem_w_ready) begin
         beats++;
         if (exp_beats.size() == 0) begin
            errors++;
            $display("write beat at %0t does not belong to any accepted write", $time);
         end else begin
            check_mem_wr(mem_w, exp_beats.pop_front());
         end
      end
   end

   initial begin
      fe_req_t              r;
      logic [FE_DATA_W-1:0] exp_data;
      logic [FE_DATA_W-1:0] got_data;
      int                   cycles;
      int                   err_before;
      bit                   ok;
      clk       = 1'b0;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      errors    = 0;
      beats     = 0;
      timed_out = 1'b0;
      for (int w = 0; w < NWORDS_MEM; w++) begin
         shadow[w] = preload_word(w);
      end
      fill_table();
      repeat (4) @(posedge clk);
      #10;
      reset = 1'b0;

      for (int i = 0; i < steps.size() && !timed_out; i++) begin
         r          = steps[i].req;
         err_before = errors;
         exp_data   = shadow[r.addr[ADDR_W-1:2]];
         send_request(r, ok);
         if (!ok) begin
            timed_out = 1'b1;
         end else if (!r.we) begin
            wait_response(cycles, got_data, ok);
            if (!ok) begin
               timed_out = 1'b1;
            end else begin
               check_latency(cycles, steps[i].exp_hit, r.addr);
               check_rdata(got_data, exp_data, r.addr);
            end
         end
         if (!timed_out) begin
            $display("entry %0d: %s %h %s", i, r.we ? "write" : "read ", r.addr,
                     (errors == err_before) ? "ok" : "mismatch");
         end
      end
      if (!timed_out) begin
         wait_beats_drained(ok);
         timed_out = !ok;
      end

      $display("%0d entries, %0d write beats, %0d errors", steps.size(), beats, errors);
      if (errors == 0 && !timed_out) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- list.f
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_write_buffer.sv
cache_write_channel.sv
cache_read_channel.sv
cache_control.sv
wt_cache_top.sv
tb_backend_mem.sv
tb_wt_cache.sv
